//--- Makefile
TOP := tb_scoreboard

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, judge sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f scoreboard.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- common/sb_pkg.sv
// Scoreboard package
// widths, word types and the enums shared by the scoreboard RTL and its
// testbench: functional unit class and per-slot status
package sb_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  // operand and result width
  localparam int unsigned XLEN = 32;
  // architectural register address width
  localparam int unsigned REG_ADDR_W = 5;
  // number of GPRs tracked by the clobber map
  localparam int unsigned NR_REGS = 2 ** REG_ADDR_W;

  // one operand or result word
  typedef logic [XLEN-1:0] data_t;
  // one register address
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ------------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------------
  // functional unit class of an instruction
  // FU_NONE completes on its own, no write-back
  typedef enum logic [1:0] {
    FU_NONE = 2'd0,
    FU_ALU  = 2'd1,
    FU_LOAD = 2'd2,
    FU_MULT = 2'd3
  } fu_e;

  // status of one ring slot
  // free -> issued -> done -> free, flush returns all to free
  typedef enum logic [1:0] {
    SLOT_FREE   = 2'd0,
    SLOT_ISSUED = 2'd1,
    SLOT_DONE   = 2'd2
  } slot_state_e;

endpackage

//--- design/scoreboard/sb_clobber.sv
// Scoreboard clobber map
// for every GPR the functional unit of the oldest-index busy slot that
// will write it, FU_NONE when no slot targets it
`timescale 1ns/1ns

module sb_clobber #(
  parameter int unsigned NrEntries = 8
) (
  input  sb_pkg::slot_state_e [NrEntries-1:0]       slot_state_i,
  input  sb_pkg::reg_addr_t   [NrEntries-1:0]       slot_rd_i,
  input  sb_pkg::fu_e         [NrEntries-1:0]       slot_fu_i,
  output sb_pkg::fu_e         [sb_pkg::NR_REGS-1:0] rd_clobber_o
);

  import sb_pkg::*;

  // ------------------------------------------------------------------------
  // fixed priority per register
  // ------------------------------------------------------------------------
  always_comb begin
    for (int r = 0; r < NR_REGS; r++) begin
      rd_clobber_o[r] = FU_NONE;
    end
    // descending walk, lower index overwrites and so wins
    for (int i = NrEntries - 1; i >= 0; i--) begin
      if (slot_state_i[i] != SLOT_FREE) begin
        rd_clobber_o[slot_rd_i[i]] = slot_fu_i[i];
      end
    end
    // x0 is always free
    rd_clobber_o[0] = FU_NONE;
  end

endmodule

//--- design/scoreboard/sb_operand_fwd.sv
// Scoreboard operand forwarding
// looks up rs1 and rs2 in the write-back port first, then in done slots
// in ascending index order; x0 never forwards
`timescale 1ns/1ns

module sb_operand_fwd #(
  parameter int unsigned NrEntries = 8
) (
  input  sb_pkg::reg_addr_t                    rs1_i,
  input  sb_pkg::reg_addr_t                    rs2_i,
  input  sb_pkg::slot_state_e [NrEntries-1:0]  slot_state_i,
  input  sb_pkg::reg_addr_t   [NrEntries-1:0]  slot_rd_i,
  input  sb_pkg::data_t       [NrEntries-1:0]  slot_result_i,
  input  logic                                 wb_valid_i,
  input  logic [$clog2(NrEntries)-1:0]         wb_trans_id_i,
  input  sb_pkg::data_t                        wb_data_i,
  output sb_pkg::data_t                        rs1_o,
  output sb_pkg::data_t                        rs2_o,
  output logic                                 rs1_valid_o,
  output logic                                 rs2_valid_o
);

  import sb_pkg::*;

  // fixed priority lookup of one source, returns the hit flag
  function automatic logic fwd_lookup(input reg_addr_t rs, output data_t data);
    logic hit;
    hit  = 1'b0;
    data = '0;
    // walk down so the lowest index is the last to write
    for (int i = NrEntries - 1; i >= 0; i--) begin
      if (slot_state_i[i] == SLOT_DONE && slot_rd_i[i] == rs) begin
        hit  = 1'b1;
        data = slot_result_i[i];
      end
    end
    // write-back port beats stored entries
    // target must be issued, late write-backs to other slots are ignored
    if (wb_valid_i && slot_state_i[wb_trans_id_i] == SLOT_ISSUED &&
        slot_rd_i[wb_trans_id_i] == rs) begin
      hit  = 1'b1;
      data = wb_data_i;
    end
    // x0 is hardwired, never forwarded
    return hit && (rs != '0);
  endfunction

  always_comb begin
    rs1_valid_o = fwd_lookup(rs1_i, rs1_o);
    rs2_valid_o = fwd_lookup(rs2_i, rs2_o);
  end

endmodule

//--- design/scoreboard/sb_pointers.sv
// Scoreboard ring pointers
// issue and commit pointers plus occupancy count, and the issue and commit
// enables derived from the handshakes
`timescale 1ns/1ns

module sb_pointers #(
  parameter int unsigned NrEntries = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         decoded_valid_i,
  input  logic                         head_done_i,
  input  logic                         commit_ready_i,
  output logic [$clog2(NrEntries)-1:0] issue_ptr_o,
  output logic [$clog2(NrEntries)-1:0] commit_ptr_o,
  output logic                         issue_en_o,
  output logic                         commit_en_o,
  output logic                         full_o
);

  localparam int unsigned IdW = $clog2(NrEntries);

  logic [IdW-1:0] issue_ptr_q;
  logic [IdW-1:0] commit_ptr_q;
  // one bit wider than the id so that NrEntries fits
  logic [IdW:0]   count_q;

  // full once the count reaches NrEntries, i.e. its top bit
  assign full_o = count_q[IdW];

  // handshakes, flush blocks both
  assign issue_en_o  = decoded_valid_i & ~full_o & ~flush_i;
  assign commit_en_o = head_done_i & commit_ready_i & ~flush_i;

  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

  // ------------------------------------------------------------------------
  // pointer and count registers
  // ------------------------------------------------------------------------
  // pointers wrap by themselves since NrEntries is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      count_q      <= '0;
    end else if (flush_i) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      count_q      <= '0;
    end else begin
      issue_ptr_q  <= issue_ptr_q + IdW'(issue_en_o);
      commit_ptr_q <= commit_ptr_q + IdW'(commit_en_o);
      // issue and retire in one cycle leave the count unchanged
      count_q      <= count_q + (IdW+1)'(issue_en_o) - (IdW+1)'(commit_en_o);
    end
  end

endmodule

//--- design/scoreboard/sb_slot_fsm.sv
// Scoreboard slot state machines
// one free/issued/done FSM per ring slot, driven by issue, write-back,
// commit and flush; flags the head slot as done
`timescale 1ns/1ns

module sb_slot_fsm #(
  parameter int unsigned NrEntries = 8
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   issue_en_i,
  input  logic [$clog2(NrEntries)-1:0]           issue_ptr_i,
  input  logic                                   fu_none_i,
  input  logic                                   commit_en_i,
  input  logic [$clog2(NrEntries)-1:0]           commit_ptr_i,
  input  logic                                   wb_valid_i,
  input  logic [$clog2(NrEntries)-1:0]           wb_trans_id_i,
  output sb_pkg::slot_state_e [NrEntries-1:0]    slot_state_o,
  output logic                                   head_done_o
);

  import sb_pkg::*;

  localparam int unsigned IdW = $clog2(NrEntries);

  slot_state_e [NrEntries-1:0] state_q;
  slot_state_e [NrEntries-1:0] state_d;
  // slot holds an FU_NONE instruction
  logic        [NrEntries-1:0] none_q;
  logic        [NrEntries-1:0] none_d;

  // ------------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    none_d  = none_q;
    for (int i = 0; i < NrEntries; i++) begin
      case (state_q[i])
        SLOT_FREE: begin
          if (issue_en_i && issue_ptr_i == IdW'(i)) begin
            state_d[i] = SLOT_ISSUED;
            none_d[i]  = fu_none_i;
          end
        end
        // FU_NONE finishes one cycle after issue, no write-back needed
        SLOT_ISSUED: begin
          if (none_q[i] || (wb_valid_i && wb_trans_id_i == IdW'(i))) begin
            state_d[i] = SLOT_DONE;
          end
        end
        SLOT_DONE: begin
          if (commit_en_i && commit_ptr_i == IdW'(i)) begin
            state_d[i] = SLOT_FREE;
          end
        end
        default: state_d[i] = SLOT_FREE;
      endcase
      // flush wins over everything
      if (flush_i) begin
        state_d[i] = SLOT_FREE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrEntries; i++) begin
        state_q[i] <= SLOT_FREE;
      end
      none_q <= '0;
    end else begin
      state_q <= state_d;
      none_q  <= none_d;
    end
  end

  assign slot_state_o = state_q;
  // head is ready to retire
  assign head_done_o  = (state_q[commit_ptr_i] == SLOT_DONE);

endmodule

//--- design/scoreboard/sb_slot_store.sv
// Scoreboard slot storage
// destination register, functional unit and result of every ring slot;
// written at the issue pointer and at the write-back id
`timescale 1ns/1ns

module sb_slot_store #(
  parameter int unsigned NrEntries = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               issue_en_i,
  input  logic [$clog2(NrEntries)-1:0]       issue_ptr_i,
  input  sb_pkg::reg_addr_t                  decoded_rd_i,
  input  sb_pkg::fu_e                        decoded_fu_i,
  input  logic                               wb_valid_i,
  input  logic [$clog2(NrEntries)-1:0]       wb_trans_id_i,
  input  sb_pkg::data_t                      wb_data_i,
  output sb_pkg::reg_addr_t [NrEntries-1:0]  slot_rd_o,
  output sb_pkg::fu_e       [NrEntries-1:0]  slot_fu_o,
  output sb_pkg::data_t     [NrEntries-1:0]  slot_result_o
);

  import sb_pkg::*;

  // ------------------------------------------------------------------------
  // instruction fields
  // ------------------------------------------------------------------------
  // rd and fu are captured at issue only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrEntries; i++) begin
        slot_rd_o[i] <= '0;
        slot_fu_o[i] <= FU_NONE;
      end
    end else if (issue_en_i) begin
      slot_rd_o[issue_ptr_i] <= decoded_rd_i;
      slot_fu_o[issue_ptr_i] <= decoded_fu_i;
    end
  end

  // ------------------------------------------------------------------------
  // results
  // ------------------------------------------------------------------------
  // cleared on issue so an FU_NONE slot commits zero
  // issue and write-back never hit the same slot, the issued one is free
  always_ff @(posedge clk_i) begin
    if (issue_en_i) begin
      slot_result_o[issue_ptr_i] <= '0;
    end
    if (wb_valid_i) begin
      slot_result_o[wb_trans_id_i] <= wb_data_i;
    end
  end

endmodule

//--- design/scoreboard/scoreboard.sv
// Instruction scoreboard top level
// ring of NrEntries slots for in-order issue, out-of-order completion;
// the slot index is the transaction id of the instruction it holds
`timescale 1ns/1ns

module scoreboard #(
  // must be a power of two
  parameter int unsigned NrEntries = 8
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      flush_i,
  // decode handshake
  input  logic                                      decoded_valid_i,
  input  sb_pkg::reg_addr_t                         decoded_rd_i,
  input  sb_pkg::fu_e                               decoded_fu_i,
  output logic                                      decoded_ready_o,
  output logic [$clog2(NrEntries)-1:0]              issue_trans_id_o,
  // write-back port
  input  logic                                      wb_valid_i,
  input  logic [$clog2(NrEntries)-1:0]              wb_trans_id_i,
  input  sb_pkg::data_t                             wb_data_i,
  // commit handshake
  output logic                                      commit_valid_o,
  input  logic                                      commit_ready_i,
  output logic [$clog2(NrEntries)-1:0]              commit_trans_id_o,
  output sb_pkg::reg_addr_t                         commit_rd_o,
  output sb_pkg::fu_e                               commit_fu_o,
  output sb_pkg::data_t                             commit_result_o,
  // operand read
  input  sb_pkg::reg_addr_t                         rs1_i,
  input  sb_pkg::reg_addr_t                         rs2_i,
  output sb_pkg::data_t                             rs1_o,
  output sb_pkg::data_t                             rs2_o,
  output logic                                      rs1_valid_o,
  output logic                                      rs2_valid_o,
  // clobber map
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]         rd_clobber_o
);

  import sb_pkg::*;

  localparam int unsigned IdW = $clog2(NrEntries);

  logic [IdW-1:0]              issue_ptr;
  logic [IdW-1:0]              commit_ptr;
  logic                        issue_en;
  logic                        commit_en;
  logic                        full;
  logic                        head_done;
  logic                        fu_none;
  slot_state_e [NrEntries-1:0] slot_state;
  reg_addr_t   [NrEntries-1:0] slot_rd;
  fu_e         [NrEntries-1:0] slot_fu;
  data_t       [NrEntries-1:0] slot_result;

  assign decoded_ready_o  = ~full;
  assign issue_trans_id_o = issue_ptr;
  assign fu_none          = (decoded_fu_i == FU_NONE);

  // head slot goes out to commit
  assign commit_valid_o    = head_done;
  assign commit_trans_id_o = commit_ptr;
  assign commit_rd_o       = slot_rd[commit_ptr];
  assign commit_fu_o       = slot_fu[commit_ptr];
  assign commit_result_o   = slot_result[commit_ptr];

  // ------------------------------------------------------------------------
  // submodules
  // ------------------------------------------------------------------------
  sb_pointers #(.NrEntries(NrEntries)) u_pointers (
    .clk_i, .rst_ni, .flush_i, .decoded_valid_i,
    .head_done_i  (head_done),
    .commit_ready_i,
    .issue_ptr_o  (issue_ptr),
    .commit_ptr_o (commit_ptr),
    .issue_en_o   (issue_en),
    .commit_en_o  (commit_en),
    .full_o       (full)
  );

  sb_slot_fsm #(.NrEntries(NrEntries)) u_slot_fsm (
    .clk_i, .rst_ni, .flush_i,
    .issue_en_i   (issue_en),
    .issue_ptr_i  (issue_ptr),
    .fu_none_i    (fu_none),
    .commit_en_i  (commit_en),
    .commit_ptr_i (commit_ptr),
    .wb_valid_i, .wb_trans_id_i,
    .slot_state_o (slot_state),
    .head_done_o  (head_done)
  );

  sb_slot_store #(.NrEntries(NrEntries)) u_slot_store (
    .clk_i, .rst_ni,
    .issue_en_i   (issue_en),
    .issue_ptr_i  (issue_ptr),
    .decoded_rd_i, .decoded_fu_i,
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .slot_rd_o     (slot_rd),
    .slot_fu_o     (slot_fu),
    .slot_result_o (slot_result)
  );

  sb_operand_fwd #(.NrEntries(NrEntries)) u_operand_fwd (
    .rs1_i, .rs2_i,
    .slot_state_i  (slot_state),
    .slot_rd_i     (slot_rd),
    .slot_result_i (slot_result),
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .rs1_o, .rs2_o, .rs1_valid_o, .rs2_valid_o
  );

  sb_clobber #(.NrEntries(NrEntries)) u_clobber (
    .slot_state_i (slot_state),
    .slot_rd_i    (slot_rd),
    .slot_fu_i    (slot_fu),
    .rd_clobber_o
  );

endmodule

//--- scoreboard.f
common/sb_pkg.sv
design/scoreboard/sb_pointers.sv
design/scoreboard/sb_slot_fsm.sv
design/scoreboard/sb_slot_store.sv
design/scoreboard/sb_operand_fwd.sv
design/scoreboard/sb_clobber.sv
design/scoreboard/scoreboard.sv
verif/scoreboard_sva.sv
verif/tb_scoreboard.sv

//--- verif/scoreboard_sva.sv
// Scoreboard assertions
// protocol and invariant checks bound into the scoreboard top level
`timescale 1ns/1ns

module scoreboard_sva #(
  parameter int unsigned NrEntries = 8
) (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input logic                                 flush_i,
  input logic                                 decoded_valid_i,
  input logic                                 decoded_ready_i,
  input logic                                 commit_valid_i,
  input logic                                 commit_ready_i,
  input sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]    rd_clobber_i
);

  import sb_pkg::*;

  localparam int unsigned IdW = $clog2(NrEntries);

  // occupancy as seen from the decode and commit handshakes
  logic [IdW:0] occ_q;
  logic         accept;
  logic         retire;

  assign accept = decoded_valid_i & decoded_ready_i & ~flush_i;
  assign retire = commit_valid_i & commit_ready_i & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else if (flush_i) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_q + (IdW+1)'(accept) - (IdW+1)'(retire);
    end
  end

  // x0 never has a pending writer
  x0_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_i[0] == FU_NONE)
    else $error("rd_clobber_o[0] is not FU_NONE");

  // flush empties the ring, so no head can be offered next cycle
  no_commit_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !commit_valid_i)
    else $error("commit_valid_o high in the cycle after a flush");

  // ring holds NrEntries at most, no accept while full
  no_accept_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (occ_q == (IdW+1)'(NrEntries)) |-> !decoded_ready_i)
    else $error("decode ready while NrEntries instructions are held");

endmodule

//--- verif/tb_scoreboard.sv
// Scoreboard testbench
// runs a table of issue, write-back, commit, flush and read steps on the
// scoreboard and checks each response against a small slot model
`timescale 1ns/1ns

module tb_scoreboard;

  import sb_pkg::*;

  localparam int unsigned NrEntries = 8;
  localparam int unsigned IdW = $clog2(NrEntries);
  // cycles any wait may take
  localparam int Timeout = 32;

  typedef enum logic [2:0] {OP_ISSUE, OP_WB, OP_COMMIT, OP_FLUSH, OP_READ} op_e;

  // one step, with the expected id and forwarding flags
  typedef struct packed {
    op_e            op;
    reg_addr_t      rd;
    fu_e            fu;
    logic [IdW-1:0] id;
    reg_addr_t      rs1;
    reg_addr_t      rs2;
    logic           v1;
    logic           v2;
  } row_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      flush_i;
  logic                      decoded_valid_i;
  reg_addr_t                 decoded_rd_i;
  fu_e                       decoded_fu_i;
  logic                      decoded_ready_o;
  logic [IdW-1:0]            issue_trans_id_o;
  logic                      wb_valid_i;
  logic [IdW-1:0]            wb_trans_id_i;
  data_t                     wb_data_i;
  logic                      commit_valid_o;
  logic                      commit_ready_i;
  logic [IdW-1:0]            commit_trans_id_o;
  reg_addr_t                 commit_rd_o;
  fu_e                       commit_fu_o;
  data_t                     commit_result_o;
  reg_addr_t                 rs1_i;
  reg_addr_t                 rs2_i;
  data_t                     rs1_o;
  data_t                     rs2_o;
  logic                      rs1_valid_o;
  logic                      rs2_valid_o;
  fu_e [NR_REGS-1:0]         rd_clobber_o;

  // slot model
  slot_state_e    m_state [NrEntries];
  reg_addr_t      m_rd    [NrEntries];
  fu_e            m_fu    [NrEntries];
  data_t          m_res   [NrEntries];
  logic           m_none  [NrEntries];
  logic [IdW-1:0] m_issue;
  logic [IdW-1:0] m_commit;
  int unsigned    m_count;

  logic [31:0]    lfsr_q;
  row_t           rows [$];
  int             errors;
  int             checks;
  int             row_errors;

  scoreboard #(.NrEntries(NrEntries)) DUT (.*);

  bind scoreboard scoreboard_sva #(.NrEntries(NrEntries)) u_sva (
    .clk_i, .rst_ni, .flush_i, .decoded_valid_i,
    .decoded_ready_i (decoded_ready_o),
    .commit_valid_i  (commit_valid_o),
    .commit_ready_i,
    .rd_clobber_i    (rd_clobber_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", what, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_fu(input string what, input fu_e got, input fu_e exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", what, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_id(input string what, input logic [IdW-1:0] got,
                          input logic [IdW-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", what, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", what, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", what, got, exp);
      row_errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // random data and the slot model
  // --------------------------------------------------------------------------
  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic next_lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic data_t random_word();
    data_t w;
    w = '0;
    for (int b = 0; b < XLEN; b++) begin
      w = {w[XLEN-2:0], next_lfsr_bit()};
    end
    return w;
  endfunction

  // one call per rising edge, with the inputs driven before it
  task automatic advance_model();
    logic accept;
    logic retire;
    accept = decoded_valid_i && (m_count < NrEntries) && !flush_i;
    retire = (m_state[m_commit] == SLOT_DONE) && commit_ready_i && !flush_i;
    for (int i = 0; i < NrEntries; i++) begin
      if (flush_i) begin
        m_state[i] = SLOT_FREE;
      end else if (m_state[i] == SLOT_ISSUED &&
                   (m_none[i] || (wb_valid_i && wb_trans_id_i == IdW'(i)))) begin
        m_state[i] = SLOT_DONE;
      end
    end
    if (wb_valid_i) begin
      m_res[wb_trans_id_i] = wb_data_i;
    end
    if (retire) begin
      m_state[m_commit] = SLOT_FREE;
      m_commit = m_commit + IdW'(1);
      m_count  = m_count - 1;
    end
    // a fresh slot starts with a zero result
    if (accept) begin
      m_state[m_issue] = SLOT_ISSUED;
      m_rd[m_issue]    = decoded_rd_i;
      m_fu[m_issue]    = decoded_fu_i;
      m_none[m_issue]  = (decoded_fu_i == FU_NONE);
      m_res[m_issue]   = '0;
      m_issue = m_issue + IdW'(1);
      m_count = m_count + 1;
    end
    if (flush_i) begin
      m_issue  = '0;
      m_commit = '0;
      m_count  = 0;
    end
  endtask

  // write-back port first, then done slots with the lowest index first
  function automatic logic expect_fwd(input reg_addr_t rs, output data_t val);
    logic hit;
    hit = 1'b0;
    val = '0;
    if (wb_valid_i && m_state[wb_trans_id_i] == SLOT_ISSUED && m_rd[wb_trans_id_i] == rs) begin
      hit = 1'b1;
      val = wb_data_i;
    end
    for (int i = 0; i < NrEntries; i++) begin
      if (!hit && m_state[i] == SLOT_DONE && m_rd[i] == rs) begin
        hit = 1'b1;
        val = m_res[i];
      end
    end
    return hit && (rs != '0);
  endfunction

  // lowest busy slot that writes r, x0 never
  function automatic fu_e expect_clobber(input int r);
    fu_e fu;
    logic hit;
    fu  = FU_NONE;
    hit = 1'b0;
    for (int i = 0; i < NrEntries; i++) begin
      if (!hit && r != 0 && m_state[i] != SLOT_FREE && m_rd[i] == reg_addr_t'(r)) begin
        hit = 1'b1;
        fu  = m_fu[i];
      end
    end
    return fu;
  endfunction

  // --------------------------------------------------------------------------
  // sequencing helpers
  // --------------------------------------------------------------------------
  task automatic tick();
    advance_model();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // registered outputs, sampled at the falling edge
  task automatic compare_state();
    for (int r = 0; r < NR_REGS; r++) begin
      check_fu($sformatf("rd_clobber_o[%0d]", r), rd_clobber_o[r], expect_clobber(r));
    end
    check_flag("commit_valid_o", commit_valid_o, m_state[m_commit] == SLOT_DONE);
    check_flag("decoded_ready_o", decoded_ready_o, m_count < NrEntries);
  endtask

  task automatic compare_operands(input row_t r);
    data_t exp1;
    data_t exp2;
    logic  ev1;
    logic  ev2;
    ev1 = expect_fwd(rs1_i, exp1);
    ev2 = expect_fwd(rs2_i, exp2);
    check_flag("rs1_valid_o", rs1_valid_o, ev1);
    check_flag("rs2_valid_o", rs2_valid_o, ev2);
    // table flags must agree too
    check_flag("rs1_valid_o", rs1_valid_o, r.v1);
    check_flag("rs2_valid_o", rs2_valid_o, r.v2);
    if (ev1) begin
      check_data("rs1_o", rs1_o, exp1);
    end
    if (ev2) begin
      check_data("rs2_o", rs2_o, exp2);
    end
  endtask

  task automatic wait_ready(output logic ok);
    int n;
    n = 0;
    while (!decoded_ready_o && n < Timeout) begin
      tick();
      n++;
    end
    ok = decoded_ready_o;
    if (!ok) begin
      $display("decoded_ready_o stayed low for %0d cycles, issue skipped", Timeout);
      row_errors++;
    end
  endtask

  task automatic wait_commit(output logic ok);
    int n;
    n = 0;
    while (!commit_valid_o && n < Timeout) begin
      tick();
      n++;
    end
    ok = commit_valid_o;
    if (!ok) begin
      $display("commit_valid_o stayed low for %0d cycles, retire skipped", Timeout);
      row_errors++;
    end
  endtask

  task automatic add_row(input op_e op, input int rd, input fu_e fu, input int id,
                         input int rs1, input int rs2, input int v1, input int v2);
    rows.push_back(row_t'{op, reg_addr_t'(rd), fu, IdW'(id), reg_addr_t'(rs1),
                          reg_addr_t'(rs2), v1 != 0, v2 != 0});
  endtask

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------
  // op, rd, fu, trans id, rs1, rs2, rs1 valid, rs2 valid
  task automatic build_table();
    add_row(OP_READ,   0, FU_NONE, 0, 5, 7, 0, 0);
    add_row(OP_ISSUE,  5, FU_ALU,  0, 0, 0, 0, 0);
    add_row(OP_ISSUE,  7, FU_LOAD, 1, 0, 0, 0, 0);
    add_row(OP_ISSUE,  5, FU_MULT, 2, 0, 0, 0, 0);
    add_row(OP_READ,   0, FU_NONE, 0, 5, 7, 0, 0);
    // out of order write-backs, then the lower slot wins on x5
    add_row(OP_WB,     0, FU_NONE, 2, 5, 0, 1, 0);
    add_row(OP_READ,   0, FU_NONE, 0, 5, 0, 1, 0);
    add_row(OP_WB,     0, FU_NONE, 0, 5, 0, 1, 0);
    add_row(OP_READ,   0, FU_NONE, 0, 5, 0, 1, 0);
    add_row(OP_READ,   0, FU_NONE, 0, 7, 5, 0, 1);
    add_row(OP_COMMIT, 0, FU_NONE, 0, 0, 0, 0, 0);
    add_row(OP_WB,     0, FU_NONE, 1, 7, 5, 1, 1);
    add_row(OP_COMMIT, 0, FU_NONE, 1, 0, 0, 0, 0);
    add_row(OP_COMMIT, 0, FU_NONE, 2, 0, 0, 0, 0);
    // completes without write-back
    add_row(OP_ISSUE,  9, FU_NONE, 3, 0, 0, 0, 0);
    add_row(OP_COMMIT, 0, FU_NONE, 3, 0, 0, 0, 0);
    // fill the ring while commit is held off
    for (int k = 0; k < NrEntries; k++) begin
      add_row(OP_ISSUE, k + 1, FU_ALU, (4 + k) % NrEntries, 0, 0, 0, 0);
    end
    add_row(OP_WB,     0, FU_NONE, 4, 1, 0, 1, 0);
    add_row(OP_COMMIT, 0, FU_NONE, 4, 0, 0, 0, 0);
    // head and slot 0 done, so the flush has a valid head to drop
    add_row(OP_WB,     0, FU_NONE, 5, 2, 0, 1, 0);
    add_row(OP_WB,     0, FU_NONE, 0, 5, 0, 1, 0);
    add_row(OP_FLUSH,  0, FU_NONE, 0, 0, 0, 0, 0);
    add_row(OP_ISSUE,  3, FU_LOAD, 0, 0, 0, 0, 0);
    add_row(OP_WB,     0, FU_NONE, 0, 3, 0, 1, 0);
    add_row(OP_COMMIT, 0, FU_NONE, 0, 0, 0, 0, 0);
  endtask

  initial begin
    logic ok;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_rd_i    = '0;
    decoded_fu_i    = FU_NONE;
    wb_valid_i      = 1'b0;
    wb_trans_id_i   = '0;
    wb_data_i       = '0;
    commit_ready_i  = 1'b0;
    rs1_i           = '0;
    rs2_i           = '0;
    lfsr_q          = 32'ha9d93705;
    errors          = 0;
    checks          = 0;
    for (int i = 0; i < NrEntries; i++) begin
      m_state[i] = SLOT_FREE;
      m_rd[i]    = '0;
      m_fu[i]    = FU_NONE;
      m_res[i]   = '0;
      m_none[i]  = 1'b0;
    end
    m_issue  = '0;
    m_commit = '0;
    m_count  = 0;
    build_table();

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    tick();

    foreach (rows[k]) begin
      row_errors = 0;
      // registered state left by the previous step
      compare_state();
      case (rows[k].op)
        OP_ISSUE: begin
          wait_ready(ok);
          if (ok) begin
            decoded_valid_i = 1'b1;
            decoded_rd_i    = rows[k].rd;
            decoded_fu_i    = rows[k].fu;
            #1;
            check_id("issue_trans_id_o", issue_trans_id_o, rows[k].id);
            tick();
          end
        end
        OP_WB: begin
          wb_valid_i    = 1'b1;
          wb_trans_id_i = rows[k].id;
          wb_data_i     = random_word();
          rs1_i         = rows[k].rs1;
          rs2_i         = rows[k].rs2;
          #1;
          // forwarded in the write cycle itself
          compare_operands(rows[k]);
          tick();
        end
        OP_COMMIT: begin
          wait_commit(ok);
          if (ok) begin
            check_id("commit_trans_id_o", commit_trans_id_o, rows[k].id);
            check_id("commit_trans_id_o", commit_trans_id_o, m_commit);
            check_reg("commit_rd_o", commit_rd_o, m_rd[m_commit]);
            check_fu("commit_fu_o", commit_fu_o, m_fu[m_commit]);
            check_data("commit_result_o", commit_result_o, m_res[m_commit]);
            commit_ready_i = 1'b1;
            tick();
            commit_ready_i = 1'b0;
          end
        end
        OP_FLUSH: begin
          flush_i = 1'b1;
          tick();
          flush_i = 1'b0;
        end
        default: begin
          rs1_i = rows[k].rs1;
          rs2_i = rows[k].rs2;
          #1;
          compare_operands(rows[k]);
          tick();
        end
      endcase
      decoded_valid_i = 1'b0;
      wb_valid_i      = 1'b0;
      errors = errors + row_errors;
      $display("row %0d %s: %s", k, rows[k].op.name(), (row_errors == 0) ? "ok" : "mismatch");
    end
    row_errors = 0;
    compare_state();
    errors = errors + row_errors;

    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
